//--- sprite_unit.f
+incdir+rtl
rtl/sprite_pkg.sv
rtl/sprite_shifter.sv
rtl/pixel_delay.sv
rtl/collision_detect.sv
rtl/sprite_unit.sv
sim/clk_gen.sv
sim/tb_sprite_unit.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timescale 1ns/1ps -Wno-fatal --top-module tb_sprite_unit \
    -f sprite_unit.f -o tb_sprite_unit &&
./obj_dir/tb_sprite_unit | tee /dev/stderr | grep -q "Verification passed" &&
echo "simulation PASSED" || { echo "simulation FAILED"; exit 1; }

//--- sim/tb_sprite_unit.sv
`default_nettype none

`include "sprite_consts.svh"

module tb_sprite_unit
    import sprite_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // every line is long enough for an expanded multicolor sprite to run out
    localparam int LINE_TICKS = 100;
    localparam int NUM_LINES  = 13;

    // in a clear strobe word m2m_clr is the top bit and imbc_clr the bottom one
    localparam coll_clr_t CLR_M2M      = 4'b1000;
    localparam coll_clr_t CLR_IMMC     = 4'b0010;
    localparam coll_clr_t CLR_IMBC     = 4'b0001;
    localparam coll_clr_t CLR_M2D_IMBC = 4'b0101;
    localparam coll_clr_t CLR_ALL      = 4'b1111;

    logic                  clk_dot4x;
    logic                  rst;
    logic                  dot_tick;
    logic [`XPOS_BITS-1:0] xpos;
    sprite_cfg_vec_t       cfg;
    fetch_t                fetch;
    logic                  bg_pixel;
    logic                  border;
    coll_clr_t             clr;
    sprite_pix_vec_t       pixels;
    sprite_mask_t          mmc_d;
    sprite_mask_t          m2m;
    sprite_mask_t          m2d;
    logic                  immc;
    logic                  imbc;

    integer        seed;
    logic [31:0]   word;
    logic [31:0]   xword;
    // sprite that gets extra bytes on tick clocks or a negative value for none
    int            fetch_sprite;
    // border rises on every tick clock when set
    logic          border_pulse;

    // reference state built from the fetch, tick and collision rules
    logic [`SHIFT_BITS-1:0] m_shift [`NUM_SPRITES];
    sprite_mask_t           m_active;
    sprite_mask_t           m_xe_ff;
    sprite_mask_t           m_mc_ff;
    sprite_mask_t           m_mmc;
    sprite_pix_vec_t        m_cur;
    sprite_pix_vec_t        m_pix_q [$];
    sprite_mask_t           m_mmc_q [$];
    logic                   m_border_q;
    logic                   m_m2m_armed;
    logic                   m_m2d_armed;
    sprite_mask_t           m_m2m;
    sprite_mask_t           m_m2d;
    logic                   m_immc;
    logic                   m_imbc;

    clk_gen clk_gen_i (
        .clk_dot4x_o (clk_dot4x),
        .rst_o       (rst)
    );

    sprite_unit dut_i (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .dot_tick_i (dot_tick),
        .xpos_i     (xpos),
        .cfg_i      (cfg),
        .fetch_i    (fetch),
        .bg_pixel_i (bg_pixel),
        .border_i   (border),
        .clr_i      (clr),
        .pixels_o   (pixels),
        .mmc_d_o    (mmc_d),
        .m2m_o      (m2m),
        .m2d_o      (m2d),
        .immc_o     (immc),
        .imbc_o     (imbc)
    );

    task automatic check_pixels(input sprite_pix_vec_t got, input sprite_pix_vec_t exp,
                                input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "pixel mismatch");
        end
    endtask

    task automatic check_mask(input sprite_mask_t got, input sprite_mask_t exp,
                              input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "mask mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    function void model_reset();
        for (int n = 0; n < `NUM_SPRITES; n++) begin
            m_shift[n] = '0;
        end
        m_active    = '0;
        m_xe_ff     = '1;
        m_mc_ff     = '1;
        m_mmc       = '0;
        m_cur       = '0;
        m_pix_q.delete();
        m_mmc_q.delete();
        for (int i = 0; i < `PIPE_DEPTH; i++) begin
            m_pix_q.push_front('0);
            m_mmc_q.push_front('0);
        end
        m_border_q  = 1'b0;
        m_m2m_armed = 1'b1;
        m_m2d_armed = 1'b1;
        m_m2m       = '0;
        m_m2d       = '0;
        m_immc      = 1'b0;
        m_imbc      = 1'b0;
    endfunction

    // one clock of the reference runs the collision rules first, then the delay
    // line and then the shifter so that each stage only sees the values of the last clock
    function void model_clock();
        sprite_pix_vec_t        pix_out;
        sprite_mask_t           mmc_out;
        sprite_mask_t           top;
        sprite_mask_t           m2d_hits;
        logic                   m2m_hit;
        logic                   m2d_hit;
        logic [`SHIFT_BITS-1:0] old;
        int                     showing;
        if (rst) begin
            model_reset();
            return;
        end
        pix_out = m_pix_q[$];
        mmc_out = m_mmc_q[$];
        showing = 0;
        for (int n = 0; n < `NUM_SPRITES; n++) begin
            top[n]      = pix_out[n][1];
            showing     = showing + int'(top[n]);
            m2d_hits[n] = mmc_out[n] ? (pix_out[n] != 2'b00) : pix_out[n][1];
        end
        m2m_hit = showing >= 2;
        // background hits count on ticks outside the border or as it rises
        if (!(dot_tick && !bg_pixel && (!border || !m_border_q))) begin
            m2d_hits = '0;
        end
        m2d_hit = m2d_hits != '0;
        m_immc = (m2m_hit && (clr.m2m_clr || m_m2m_armed)) || (m_immc && !clr.immc_clr);
        m_imbc = (m2d_hit && (clr.m2d_clr || m_m2d_armed)) || (m_imbc && !clr.imbc_clr);
        m_m2m_armed = !m2m_hit && (clr.m2m_clr || m_m2m_armed);
        m_m2d_armed = !m2d_hit && (clr.m2d_clr || m_m2d_armed);
        m_m2m = (clr.m2m_clr ? '0 : m_m2m) | (m2m_hit ? top : '0);
        m_m2d = (clr.m2d_clr ? '0 : m_m2d) | m2d_hits;
        m_border_q = border;

        if (dot_tick) begin
            m_pix_q.push_front(m_cur);
            m_mmc_q.push_front(m_mmc);
            void'(m_pix_q.pop_back());
            void'(m_mmc_q.pop_back());
        end

        for (int n = 0; n < `NUM_SPRITES; n++) begin
            old = m_shift[n];
            if (dot_tick) begin
                if (cfg[n].en && !m_active[n] && cfg[n].x == xpos) begin
                    m_active[n] = 1'b1;
                    m_xe_ff[n]  = 1'b1;
                    m_mc_ff[n]  = 1'b1;
                end
                if (m_active[n] && old == '0 && m_cur[n] == 2'b00) begin
                    m_active[n] = 1'b0;
                end else if (m_active[n]) begin
                    if (m_xe_ff[n]) begin
                        if (!cfg[n].mmc) begin
                            m_cur[n] = {old[`SHIFT_BITS-1], 1'b0};
                        end else if (m_mc_ff[n]) begin
                            m_cur[n] = old[`SHIFT_BITS-1 -: 2];
                        end
                        if (cfg[n].mmc) begin
                            m_mc_ff[n] = !m_mc_ff[n];
                        end
                        m_mmc[n]   = cfg[n].mmc;
                        m_shift[n] = old << 1;
                    end
                    m_xe_ff[n] = cfg[n].xe ? !m_xe_ff[n] : 1'b1;
                end
            end
            // the fetched byte wins over the tick shift
            if (fetch.valid && fetch.idx == n) begin
                m_shift[n] = {old[`SHIFT_BITS-`FETCH_BITS-1:0], fetch.data};
            end
        end
    endfunction

    always @(posedge clk_dot4x) begin
        model_clock();
    end

    // all outputs are registers, so they are steady on the falling edge
    always @(negedge clk_dot4x) begin
        if (!rst) begin
            check_pixels(pixels, m_pix_q[$], "pixels_o");
            check_mask(mmc_d, m_mmc_q[$], "mmc_d_o");
            check_mask(m2m, m_m2m, "m2m_o");
            check_mask(m2d, m_m2d, "m2d_o");
            check_flag(immc, m_immc, "immc_o");
            check_flag(imbc, m_imbc, "imbc_o");
        end
    end

    // strobes last a single clock unless set again
    task automatic next_clock(input logic tick);
        @(negedge clk_dot4x);
        dot_tick = tick;
        fetch    = '0;
        clr      = '0;
    endtask

    task automatic pulse_clear(input coll_clr_t c);
        next_clock(1'b0);
        clr = c;
        next_clock(1'b0);
    endtask

    task automatic arm_sprite(input int s, input logic xe, input logic mc,
                              input logic [`SHIFT_BITS-1:0] bits,
                              input logic [`XPOS_BITS-1:0] x);
        for (int b = 0; b < `SHIFT_BITS / `FETCH_BITS; b++) begin
            next_clock(1'b0);
            fetch = '{valid: 1'b1, idx: s[`SPRITE_IDX_BITS-1:0],
                      data: bits[`SHIFT_BITS-1-`FETCH_BITS*b -: `FETCH_BITS]};
        end
        cfg[s] = '{x: x, en: 1'b1, xe: xe, mmc: mc};
    endtask

    // a raster line moves the position on in the first clock of each pixel
    task automatic run_line();
        for (int t = 0; t < LINE_TICKS; t++) begin
            for (int c = 0; c < 4; c++) begin
                next_clock(c == 3);
                if (c == 0) begin
                    xpos = t[`XPOS_BITS-1:0];
                    if (border_pulse) begin
                        border = 1'b0;
                    end
                end
                if (c == 3) begin
                    if (border_pulse) begin
                        border = 1'b1;
                    end
                    if (fetch_sprite >= 0 && t % 5 == 2) begin
                        word  = $random(seed);
                        fetch = '{valid: 1'b1, idx: fetch_sprite[`SPRITE_IDX_BITS-1:0],
                                  data: word[`FETCH_BITS-1:0]};
                    end
                end
            end
        end
        next_clock(1'b0);
        cfg = '0;
    endtask

    task automatic show_one(input int s, input logic xe, input logic mc);
        word  = $random(seed);
        xword = $random(seed);
        arm_sprite(s, xe, mc, word[`SHIFT_BITS-1:0], {4'd0, xword[4:0]});
        run_line();
    endtask

    initial begin
        seed         = 32'h4d6e;
        dot_tick     = 1'b0;
        xpos         = '0;
        cfg          = '0;
        fetch        = '0;
        bg_pixel     = 1'b0;
        border       = 1'b0;
        clr          = '0;
        fetch_sprite = -1;
        border_pulse = 1'b0;

        wait (!rst);
        next_clock(1'b0);
        check_pixels(pixels, '0, "pixels_o after reset");
        check_mask(mmc_d, '0, "mmc_d_o after reset");
        check_mask(m2m, '0, "m2m_o after reset");
        check_mask(m2d, '0, "m2d_o after reset");
        check_flag(immc, 1'b0, "immc_o after reset");
        check_flag(imbc, 1'b0, "imbc_o after reset");

        // single color first and then expand-x, multicolor and both at once
        show_one(0, 1'b0, 1'b0);
        show_one(1, 1'b1, 1'b0);
        show_one(2, 1'b0, 1'b1);
        show_one(3, 1'b1, 1'b1);

        // two solid sprites on top of each other with background hits masked off
        pulse_clear(CLR_ALL);
        bg_pixel = 1'b1;
        xword    = $random(seed);
        arm_sprite(4, 1'b0, 1'b0, '1, {4'd0, xword[4:0]});
        arm_sprite(5, 1'b0, 1'b0, '1, {4'd0, xword[4:0]});
        run_line();
        check_flag(immc, 1'b1, "immc_o on first overlap");
        check_mask(m2m, 8'h30, "m2m_o on first overlap");
        pulse_clear(CLR_IMMC);
        check_flag(immc, 1'b0, "immc_o after its clear");
        arm_sprite(4, 1'b0, 1'b0, '1, {4'd0, xword[4:0]});
        arm_sprite(5, 1'b0, 1'b0, '1, {4'd0, xword[4:0]});
        run_line();
        check_flag(immc, 1'b0, "immc_o before the mask clear");
        pulse_clear(CLR_M2M);
        check_mask(m2m, '0, "m2m_o after its clear");
        arm_sprite(4, 1'b0, 1'b0, '1, {4'd0, xword[4:0]});
        arm_sprite(5, 1'b0, 1'b0, '1, {4'd0, xword[4:0]});
        run_line();
        check_flag(immc, 1'b1, "immc_o after re-arm");

        // background collisions with a multicolor sprite
        pulse_clear(CLR_ALL);
        bg_pixel = 1'b0;
        word     = $random(seed);
        arm_sprite(2, 1'b0, 1'b1, word[`SHIFT_BITS-1:0] | 24'hc00000, 9'd7);
        run_line();
        check_flag(imbc, 1'b1, "imbc_o on background hit");
        check_mask(m2d, 8'h04, "m2d_o on background hit");
        pulse_clear(CLR_M2D_IMBC);
        bg_pixel = 1'b1;
        arm_sprite(2, 1'b0, 1'b1, 24'hffffff, 9'd7);
        run_line();
        check_flag(imbc, 1'b0, "imbc_o with background pixel set");
        bg_pixel = 1'b0;
        border   = 1'b1;
        arm_sprite(2, 1'b0, 1'b1, 24'hffffff, 9'd7);
        run_line();
        check_flag(imbc, 1'b0, "imbc_o with border held");

        // a border rise on each tick lets single color pixels collide
        border_pulse = 1'b1;
        word         = $random(seed);
        arm_sprite(0, 1'b0, 1'b0, word[`SHIFT_BITS-1:0] | 24'h800000, 9'd3);
        run_line();
        check_flag(imbc, 1'b1, "imbc_o on border rise");
        check_mask(m2d, 8'h01, "m2d_o on border rise");

        // with only the flag cleared the fired state keeps further hits quiet
        pulse_clear(CLR_IMBC);
        check_flag(imbc, 1'b0, "imbc_o after its clear");
        arm_sprite(0, 1'b0, 1'b0, word[`SHIFT_BITS-1:0] | 24'h800000, 9'd3);
        run_line();
        check_flag(imbc, 1'b0, "imbc_o before the mask clear");
        border_pulse = 1'b0;
        border       = 1'b0;

        // fresh bytes arrive on tick clocks while sprite 6 is shown
        fetch_sprite = 6;
        word         = $random(seed);
        arm_sprite(6, 1'b1, 1'b0, word[`SHIFT_BITS-1:0], 9'd5);
        run_line();
        fetch_sprite = -1;
        next_clock(1'b0);

        $display("Verification passed");
        $finish;
    end

    // each line costs four clocks per tick and the loads and clears need some slack on top
    initial begin
        #(NUM_LINES * LINE_TICKS * 4 * 40 + 20000);
        $display("timeout: the test sequence did not finish in time");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- sim/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk_dot4x_o,
    output logic rst_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period, the pixel tick comes every fourth clock
    initial begin
        clk_dot4x_o = 1'b0;
        forever begin
            #20 clk_dot4x_o = ~clk_dot4x_o;
        end
    end

    // reset spans ten rising edges and drops on a falling edge like the stimulus
    initial begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_dot4x_o);
        @(negedge clk_dot4x_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- rtl/sprite_unit.sv
`default_nettype none

`include "sprite_consts.svh"

module sprite_unit
    import sprite_pkg::*;
(
    input  wire logic                  clk_dot4x,
    input  wire logic                  rst,
    input  wire logic                  dot_tick_i,
    input  wire logic [`XPOS_BITS-1:0] xpos_i,
    input  sprite_cfg_vec_t            cfg_i,
    input  fetch_t                     fetch_i,
    input  wire logic                  bg_pixel_i,
    input  wire logic                  border_i,
    input  coll_clr_t                  clr_i,
    output sprite_pix_vec_t            pixels_o,
    output sprite_mask_t               mmc_d_o,
    output sprite_mask_t               m2m_o,
    output sprite_mask_t               m2d_o,
    output logic                       immc_o,
    output logic                       imbc_o
);

    // pixels and mode flags as they leave the shifter
    sprite_pix_vec_t pix_now;
    sprite_mask_t    mmc_now;

    // the same values after the alignment delay
    sprite_pix_vec_t pix_d;
    sprite_mask_t    mmc_d;

    sprite_shifter u_shifter (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .dot_tick_i (dot_tick_i),
        .xpos_i     (xpos_i),
        .cfg_i      (cfg_i),
        .fetch_i    (fetch_i),
        .pix_o      (pix_now),
        .mmc_o      (mmc_now)
    );

    // the mode flags travel next to their pixels so the overlay and the
    // collision logic see the mode each pixel was made with
    pixel_delay #(
        .payload_t (sprite_pix_vec_t)
    ) u_pix_delay (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .dot_tick_i (dot_tick_i),
        .d_i        (pix_now),
        .q_o        (pix_d)
    );

    pixel_delay #(
        .payload_t (sprite_mask_t)
    ) u_mmc_delay (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .dot_tick_i (dot_tick_i),
        .d_i        (mmc_now),
        .q_o        (mmc_d)
    );

    // collisions are judged on the delayed pixels, as they are overlaid
    collision_detect u_collision (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .dot_tick_i (dot_tick_i),
        .pix_i      (pix_d),
        .mmc_i      (mmc_d),
        .bg_pixel_i (bg_pixel_i),
        .border_i   (border_i),
        .clr_i      (clr_i),
        .m2m_o      (m2m_o),
        .m2d_o      (m2d_o),
        .immc_o     (immc_o),
        .imbc_o     (imbc_o)
    );

    assign pixels_o = pix_d;
    assign mmc_d_o  = mmc_d;

endmodule

`default_nettype wire

//--- rtl/collision_detect.sv
`default_nettype none

`include "sprite_consts.svh"

module collision_detect
    import sprite_pkg::*;
(
    input  wire logic clk_dot4x,
    input  wire logic rst,
    input  wire logic dot_tick_i,
    input  sprite_pix_vec_t pix_i,
    input  sprite_mask_t    mmc_i,
    input  wire logic bg_pixel_i,
    input  wire logic border_i,
    input  coll_clr_t       clr_i,
    output sprite_mask_t    m2m_o,
    output sprite_mask_t    m2d_o,
    output logic            immc_o,
    output logic            imbc_o
);

    // an interrupt may fire once, then waits for its mask clear
    typedef enum logic {
        ST_ARMED = 1'b0,
        ST_FIRED = 1'b1
    } coll_state_e;

    coll_state_e m2m_state_q;
    coll_state_e m2d_state_q;

    logic         border_q;
    logic         border_rise;
    sprite_mask_t top_bits;
    sprite_mask_t m2d_cand;
    sprite_mask_t m2m_hits;
    sprite_mask_t m2d_hits;
    logic         m2m_hit;
    logic         m2d_hit;
    logic         m2d_allow;
    logic         m2m_fire;
    logic         m2d_fire;

    // the clear re-arms first so a collision in the same clock still fires
    function automatic logic fire_now(coll_state_e cur, logic rearm, logic hit);
        return hit && (rearm || cur == ST_ARMED);
    endfunction

    function automatic coll_state_e state_next(coll_state_e cur, logic rearm, logic hit);
        coll_state_e nxt;
        nxt = rearm ? ST_ARMED : cur;
        if (hit) begin
            nxt = ST_FIRED;
        end
        return nxt;
    endfunction

    // the last pixel before the border still counts for background hits
    assign border_rise = border_i && !border_q;

    always_comb begin
        for (int n = 0; n < `NUM_SPRITES; n++) begin
            top_bits[n] = pix_i[n][1];
            // multicolor pixels collide on any colour, single color on the top bit
            m2d_cand[n] = mmc_i[n] ? (pix_i[n] != 2'b00) : pix_i[n][1];
        end
    end

    // a sprite-to-sprite hit needs at least two sprites showing at once
    assign m2m_hit  = (top_bits & (top_bits - 1'b1)) != '0;
    assign m2m_hits = m2m_hit ? top_bits : '0;

    assign m2d_allow = dot_tick_i && !bg_pixel_i && (!border_i || border_rise);
    assign m2d_hits  = m2d_allow ? m2d_cand : '0;
    assign m2d_hit   = |m2d_hits;

    assign m2m_fire = fire_now(m2m_state_q, clr_i.m2m_clr, m2m_hit);
    assign m2d_fire = fire_now(m2d_state_q, clr_i.m2d_clr, m2d_hit);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            border_q    <= 1'b0;
            m2m_state_q <= ST_ARMED;
            m2d_state_q <= ST_ARMED;
            m2m_o       <= '0;
            m2d_o       <= '0;
            immc_o      <= 1'b0;
            imbc_o      <= 1'b0;
        end else begin
            border_q    <= border_i;
            m2m_state_q <= state_next(m2m_state_q, clr_i.m2m_clr, m2m_hit);
            m2d_state_q <= state_next(m2d_state_q, clr_i.m2d_clr, m2d_hit);

            // new hits are ORed in after the clear so they are never lost
            m2m_o <= (clr_i.m2m_clr ? '0 : m2m_o) | m2m_hits;
            m2d_o <= (clr_i.m2d_clr ? '0 : m2d_o) | m2d_hits;

            immc_o <= m2m_fire || (immc_o && !clr_i.immc_clr);
            imbc_o <= m2d_fire || (imbc_o && !clr_i.imbc_clr);
        end
    end

endmodule

`default_nettype wire

//--- rtl/pixel_delay.sv
`default_nettype none

`include "sprite_consts.svh"

module pixel_delay
    import sprite_pkg::*;
#(
    parameter type payload_t = sprite_mask_t
) (
    input  wire logic clk_dot4x,
    input  wire logic rst,
    input  wire logic dot_tick_i,
    input  payload_t  d_i,
    output payload_t  q_o
);

    // one register per pixel tick of delay
    payload_t stage_q [`PIPE_DEPTH];

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (dot_tick_i) begin
            // everything moves one slot per pixel so up to PIPE_DEPTH
            // values are in flight at once
            stage_q[0] <= d_i;
            for (int i = 1; i < `PIPE_DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // the last slot lines up with the graphics overlay stage
    assign q_o = stage_q[`PIPE_DEPTH-1];

endmodule

`default_nettype wire

//--- rtl/sprite_shifter.sv
`default_nettype none

`include "sprite_consts.svh"

module sprite_shifter
    import sprite_pkg::*;
(
    input  wire logic                  clk_dot4x,
    input  wire logic                  rst,
    input  wire logic                  dot_tick_i,
    input  wire logic [`XPOS_BITS-1:0] xpos_i,
    input  sprite_cfg_vec_t            cfg_i,
    input  fetch_t                     fetch_i,
    output sprite_pix_vec_t            pix_o,
    output sprite_mask_t               mmc_o
);

    // the data bytes of each sprite line, oldest byte at the top
    logic [`SHIFT_BITS-1:0] shift_q [`NUM_SPRITES];
    logic [`SHIFT_BITS-1:0] shift_d [`NUM_SPRITES];

    // a sprite is active from its x match until its data runs out
    sprite_mask_t active_q;
    sprite_mask_t active_d;

    // expand flop, a pixel is only produced when it is set
    sprite_mask_t xe_ff_q;
    sprite_mask_t xe_ff_d;

    // multicolor flop, picks every second tick for a new bit pair
    sprite_mask_t mc_ff_q;
    sprite_mask_t mc_ff_d;

    // multicolor mode that was in force when each pixel was made
    sprite_mask_t mmc_q;
    sprite_mask_t mmc_d;

    // current pixel of every sprite, held while a sprite is idle
    sprite_pix_vec_t cur_q;
    sprite_pix_vec_t cur_d;

    always_comb begin
        for (int n = 0; n < `NUM_SPRITES; n++) begin
            active_d[n] = active_q[n];
            xe_ff_d[n]  = xe_ff_q[n];
            mc_ff_d[n]  = mc_ff_q[n];
            mmc_d[n]    = mmc_q[n];
            cur_d[n]    = cur_q[n];
            shift_d[n]  = shift_q[n];

            if (dot_tick_i) begin
                // the x match starts the sprite with both flops set so
                // the first pixel comes out on this very tick
                if (cfg_i[n].en && !active_q[n] && cfg_i[n].x == xpos_i) begin
                    active_d[n] = 1'b1;
                    xe_ff_d[n]  = 1'b1;
                    mc_ff_d[n]  = 1'b1;
                end

                if (active_d[n]) begin
                    if (shift_q[n] == '0 && cur_q[n] == 2'b00) begin
                        // nothing left to show, the sprite goes idle
                        active_d[n] = 1'b0;
                    end else begin
                        if (xe_ff_d[n]) begin
                            if (cfg_i[n].mmc) begin
                                // a bit pair is taken on every other pixel
                                // and is shown for two pixels
                                if (mc_ff_d[n]) begin
                                    cur_d[n] = shift_q[n][`SHIFT_BITS-1 -: 2];
                                end
                                mc_ff_d[n] = !mc_ff_d[n];
                            end else begin
                                cur_d[n] = {shift_q[n][`SHIFT_BITS-1], 1'b0};
                            end
                            mmc_d[n]   = cfg_i[n].mmc;
                            shift_d[n] = {shift_q[n][`SHIFT_BITS-2:0], 1'b0};
                        end
                        // with x expansion every pixel is held for two ticks
                        xe_ff_d[n] = cfg_i[n].xe ? !xe_ff_d[n] : 1'b1;
                    end
                end
            end

            // a fetched byte enters at the bottom and overrides the tick shift
            if (fetch_i.valid && int'(fetch_i.idx) == n) begin
                shift_d[n] = {shift_q[n][`SHIFT_BITS-`FETCH_BITS-1:0], fetch_i.data};
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            active_q <= '0;
            xe_ff_q  <= '1;
            mc_ff_q  <= '1;
            mmc_q    <= '0;
            cur_q    <= '0;
            for (int n = 0; n < `NUM_SPRITES; n++) begin
                shift_q[n] <= '0;
            end
        end else begin
            active_q <= active_d;
            xe_ff_q  <= xe_ff_d;
            mc_ff_q  <= mc_ff_d;
            mmc_q    <= mmc_d;
            cur_q    <= cur_d;
            for (int n = 0; n < `NUM_SPRITES; n++) begin
                shift_q[n] <= shift_d[n];
            end
        end
    end

    // the current pixels and their mode flags enter the delay lines
    assign pix_o = cur_q;
    assign mmc_o = mmc_q;

endmodule

`default_nettype wire

//--- rtl/sprite_pkg.sv
`default_nettype none

`include "sprite_consts.svh"

package sprite_pkg;

    // a single sprite pixel, zero means transparent
    // in single color mode only the top bit carries the pixel
    typedef logic [1:0] sprite_pix_t;

    // one pixel per sprite, sprite 0 in the lowest slot
    typedef sprite_pix_t [`NUM_SPRITES-1:0] sprite_pix_vec_t;

    // one bit per sprite, used for multicolor flags and collision masks
    typedef logic [`NUM_SPRITES-1:0] sprite_mask_t;

    // per sprite settings as seen by the pixel engine
    typedef struct packed {
        logic [`XPOS_BITS-1:0] x;
        logic                  en;
        logic                  xe;
        logic                  mmc;
    } sprite_cfg_t;

    typedef sprite_cfg_t [`NUM_SPRITES-1:0] sprite_cfg_vec_t;

    // a fetched data byte and the sprite it belongs to
    typedef struct packed {
        logic                        valid;
        logic [`SPRITE_IDX_BITS-1:0] idx;
        logic [`FETCH_BITS-1:0]      data;
    } fetch_t;

    // clear strobes for the collision masks and interrupt flags
    typedef struct packed {
        logic m2m_clr;
        logic m2d_clr;
        logic immc_clr;
        logic imbc_clr;
    } coll_clr_t;

endpackage

`default_nettype wire

//--- rtl/sprite_consts.svh
`ifndef SPRITE_CONSTS_SVH
`define SPRITE_CONSTS_SVH

// number of hardware sprites handled by the engine
`define NUM_SPRITES 8

// each sprite line is three fetched bytes wide
`define SHIFT_BITS 24

// pixel ticks between a produced sprite pixel and the overlay stage
`define PIPE_DEPTH 6

// width of the horizontal raster position and of the sprite x register
`define XPOS_BITS 9

// width of one byte from the sprite data fetch
`define FETCH_BITS 8

// width of a sprite index, enough to address every sprite
`define SPRITE_IDX_BITS 3

`endif
